//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);    // Release away from the active edge
        rst_n = 1'b1;
    end

endmodule

//--- bench/decode_tb.sv
`timescale 1ns/1ps

module decode_tb;

    localparam int period          = 40;
    localparam int reset_cycles    = 3;
    localparam int num_ops         = 38;
    localparam int reps_per_op     = 3;
    localparam int num_illegal     = 20;
    localparam int num_except      = 10;
    localparam int num_flush       = 8;
    localparam int num_hold_rounds = 20;
    localparam int max_hold        = 6;
    localparam int num_random      = 300;
    localparam int max_vectors     = num_ops * reps_per_op + num_illegal + num_except +
                                     2 * num_flush + num_hold_rounds * (max_hold + 2) + num_random;
    localparam int time_limit      = (max_vectors + reset_cycles + 10) * period;

    localparam logic [9:0]  imm_ops [0:5]    = '{10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e,
                                                 10'h00f};
    localparam logic [16:0] reg_ops [0:10]   = '{17'h20, 17'h22, 17'h24, 17'h25, 17'h28, 17'h29,
                                                 17'h2a, 17'h2b, 17'h2e, 17'h2f, 17'h30};
    localparam logic [16:0] shift_ops [0:2]  = '{17'h81, 17'h89, 17'h91};
    localparam logic [16:0] mdu_ops [0:6]    = '{17'h40, 17'h41, 17'h42, 17'h43, 17'h38, 17'h39,
                                                 17'h3a};    // Indexed by MDU op code

    typedef struct packed {
        logic [31:0] pc;
        logic [2:0]  exc;
        logic        vld;
        logic [1:0]  unit;
        logic [4:0]  alu_op;
        logic [2:0]  mdu_op;
        logic [3:0]  bru_op;
        logic [19:0] alu_imm;
        logic [25:0] bru_imm;
        logic        dest_en;
        logic [4:0]  dest;
        logic        src1_en;
        logic [4:0]  src1;
        logic        src2_en;
        logic [4:0]  src2;
    } outs_t;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        hold;
    logic [1:0]  except_in;
    logic [31:0] pc_in;
    logic        instruction_vld;
    logic [31:0] instruction;
    logic [31:0] pc_out;
    logic [2:0]  except_out;
    logic        decode_vld;
    logic [1:0]  issue_unit;
    logic [4:0]  alu_op;
    logic [2:0]  mdu_op;
    logic [3:0]  bru_op;
    logic [19:0] alu_imm;
    logic [25:0] bru_imm;
    logic        dest_en;
    logic [4:0]  dest;
    logic        src1_en;
    logic [4:0]  src1;
    logic        src2_en;
    logic [4:0]  src2;

    outs_t expected;
    int    errors = 0;
    int    checks = 0;

    clock_gen #(.period(period), .reset_cycles(reset_cycles)) u_clk (.clk(clk), .rst_n(rst_n));

    decode_top #(.pc_w(32)) dut (.*);

    // Index 0 LU12I, 1..20 other ALU, 21..27 MDU, 28 PCADDU12I, 29..37 branches
    function automatic logic [31:0] make_instr(input int idx, input logic [31:0] r);
        if (idx == 0) return {7'h0a, r[24:0]};
        if (idx <= 6) return {imm_ops[idx - 1], r[21:0]};
        if (idx <= 17) return {reg_ops[idx - 7], r[14:0]};
        if (idx <= 20) return {shift_ops[idx - 18], r[14:0]};
        if (idx <= 27) return {mdu_ops[idx - 21], r[14:0]};
        if (idx == 28) return {7'h0e, r[24:0]};
        return {6'(8'h13 + idx - 29), r[25:0]};
    endfunction

    function automatic outs_t ref_decode(input logic [31:0] ins);
        outs_t o;
        logic  pcaddu;
        logic  cond;
        o      = '0;
        pcaddu = (ins[31:25] == 7'h0e);
        cond   = (ins[31:26] >= 6'h16) && (ins[31:26] <= 6'h1b);
        if (ins[31:25] == 7'h0a) o.unit = 2'd1;    // LU12I keeps op 0
        for (int i = 0; i < 6; i++) begin
            if (ins[31:22] == imm_ops[i]) begin
                o.unit   = 2'd1;
                o.alu_op = 5'(i + 1);
            end
        end
        for (int i = 0; i < 11; i++) begin
            if (ins[31:15] == reg_ops[i]) begin
                o.unit    = 2'd1;
                o.alu_op  = 5'(i + 7);
                o.src2_en = 1'b1;
            end
        end
        for (int i = 0; i < 3; i++) begin
            if (ins[31:15] == shift_ops[i]) begin
                o.unit   = 2'd1;
                o.alu_op = 5'(i + 21);
            end
        end
        for (int i = 0; i < 7; i++) begin
            if (ins[31:15] == mdu_ops[i]) begin
                o.unit    = 2'd2;
                o.mdu_op  = 3'(i);
                o.src2_en = 1'b1;
            end
        end
        if (pcaddu || (ins[31:26] >= 6'h13 && ins[31:26] <= 6'h1b)) begin
            o.unit    = 2'd3;
            o.bru_op  = pcaddu ? 4'd0 : 4'(ins[31:26] - 6'h12);
            o.src2_en = cond;
        end
        if (o.unit == 2'd0) return o;
        o.vld     = 1'b1;
        o.dest_en = (o.unit != 2'd3) || (o.bru_op inside {4'd0, 4'd1, 4'd3});
        o.dest    = (o.unit == 2'd3 && o.bru_op == 4'd3) ? 5'd1 : ins[4:0];
        o.src1    = ins[9:5];
        o.src1_en = !(o.unit == 2'd1 && o.alu_op == 5'd0) &&
                    !(o.unit == 2'd3 && (o.bru_op inside {4'd0, 4'd2, 4'd3}));
        o.src2    = cond ? ins[4:0] : ins[14:10];
        if (o.unit == 2'd1) begin
            o.alu_imm = (o.alu_op == 5'd0) ? ins[24:5] : {8'd0, ins[21:10]};
        end
        if (o.unit == 2'd3) begin
            if (o.bru_op == 4'd0) o.bru_imm = {6'd0, ins[24:5]};
            else if (o.bru_op inside {4'd2, 4'd3}) o.bru_imm = {ins[9:0], ins[25:10]};
            else o.bru_imm = {10'd0, ins[25:10]};
        end
        return o;
    endfunction

    // Stage register state after one rising edge
    function automatic outs_t next_state(input outs_t cur, input logic f, input logic h,
                                         input logic [1:0] e, input logic [31:0] pc,
                                         input logic v, input logic [31:0] ins);
        outs_t nxt;
        nxt = '0;
        if (h && !f) begin
            nxt = cur;
        end else if (!f && e != 2'd0) begin
            nxt.pc  = pc;
            nxt.exc = {1'b0, e};
        end else if (!f && v) begin
            nxt     = ref_decode(ins);
            nxt.pc  = pc;
            nxt.exc = nxt.vld ? 3'd0 : 3'd4;
        end else if (!f) begin
            nxt.pc = cur.pc;    // Idle keeps the PC only
        end
        return nxt;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic check_outputs();
        compare("pc_out", pc_out, expected.pc);
        compare("except_out", 32'(except_out), 32'(expected.exc));
        compare("decode_vld", 32'(decode_vld), 32'(expected.vld));
        compare("issue_unit", 32'(issue_unit), 32'(expected.unit));
        compare("alu_op", 32'(alu_op), 32'(expected.alu_op));
        compare("mdu_op", 32'(mdu_op), 32'(expected.mdu_op));
        compare("bru_op", 32'(bru_op), 32'(expected.bru_op));
        compare("alu_imm", 32'(alu_imm), 32'(expected.alu_imm));
        compare("bru_imm", 32'(bru_imm), 32'(expected.bru_imm));
        compare("dest_en", 32'(dest_en), 32'(expected.dest_en));
        compare("dest", 32'(dest), 32'(expected.dest));
        compare("src1_en", 32'(src1_en), 32'(expected.src1_en));
        compare("src1", 32'(src1), 32'(expected.src1));
        compare("src2_en", 32'(src2_en), 32'(expected.src2_en));
        compare("src2", 32'(src2), 32'(expected.src2));
    endtask

    task automatic drive(input logic f, input logic h, input logic [1:0] e, input logic v,
                         input logic [31:0] ins);
        logic [31:0] pc;
        pc = $urandom;
        @(negedge clk);
        flush           = f;
        hold            = h;
        except_in       = e;
        pc_in           = pc;
        instruction_vld = v;
        instruction     = ins;
        expected        = next_state(expected, f, h, e, pc, v, ins);
    endtask

    initial begin
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            #5;    // Outputs settled, inputs change at the falling edge
            check_outputs();
        end
    end

    initial begin
        #(time_limit);
        $display("Timeout: run did not finish within %0d ns", time_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        outs_t       probe;
        logic [31:0] ins;
        int          len;
        void'($urandom(63));
        flush           = 1'b0;
        hold            = 1'b0;
        except_in       = 2'd0;
        pc_in           = 32'd0;
        instruction_vld = 1'b0;
        instruction     = 32'd0;
        expected        = '0;
        wait (rst_n === 1'b1);

        for (int idx = 0; idx < num_ops; idx++) begin
            repeat (reps_per_op) drive(1'b0, 1'b0, 2'd0, 1'b1, make_instr(idx, $urandom));
        end

        for (int n = 0; n < num_illegal; n++) begin
            ins   = $urandom;
            probe = ref_decode(ins);
            while (probe.vld) begin
                ins   = $urandom;
                probe = ref_decode(ins);
            end
            drive(1'b0, 1'b0, 2'd0, 1'b1, ins);
        end

        for (int n = 0; n < num_except; n++) begin
            drive(1'b0, 1'b0, 2'($urandom_range(1, 3)), 1'($urandom_range(0, 1)),
                  make_instr($urandom_range(0, num_ops - 1), $urandom));
        end

        for (int n = 0; n < num_flush; n++) begin
            drive(1'b0, 1'b0, 2'd0, 1'b1, make_instr($urandom_range(0, num_ops - 1), $urandom));
            drive(1'b1, 1'($urandom_range(0, 1)), 2'($urandom_range(0, 3)), 1'b1, $urandom);
        end

        for (int n = 0; n < num_hold_rounds; n++) begin
            drive(1'b0, 1'b0, 2'd0, 1'b1, make_instr($urandom_range(0, num_ops - 1), $urandom));
            len = $urandom_range(1, max_hold);
            repeat (len) begin
                drive(1'b0, 1'b1, 2'($urandom_range(0, 3)), 1'($urandom_range(0, 1)), $urandom);
            end
            drive(1'b0, 1'b0, 2'd0, 1'b0, $urandom);    // Idle cycle clears the fields
        end

        for (int n = 0; n < num_random; n++) begin
            ins = ($urandom_range(0, 3) == 0) ? $urandom :
                  make_instr($urandom_range(0, num_ops - 1), $urandom);
            drive($urandom_range(0, 7) == 0, $urandom_range(0, 3) == 0,
                  ($urandom_range(0, 7) == 0) ? 2'($urandom_range(1, 3)) : 2'd0,
                  $urandom_range(0, 3) != 0, ins);
        end

        drive(1'b0, 1'b0, 2'd0, 1'b0, 32'd0);
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- decode_top.f
src/decode_pkg.sv
src/decode_if.sv
src/issue_classifier.sv
src/alu_decoder.sv
src/branch_decoder.sv
src/operand_decoder.sv
src/decode_stage_reg.sv
src/decode_top.sv
bench/clock_gen.sv
bench/decode_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module decode_tb \
    -f decode_top.f --Mdir obj_dir -o decode_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/decode_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$log"; then
    exit 1
fi
exit 0

//--- src/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder import decode_pkg::*; (
    input  logic [instr_w-1:0] instruction,
    decode_if.alu_mp           dif
);

    logic is_lu12i;

    assign is_lu12i = (instruction[31:25] == 7'h0a);

    always_comb begin
        dif.alu_op = alu_op_e'('0);
        if (dif.unit == IQ_ALU) begin
            if (is_lu12i) begin
                dif.alu_op = ALU_LU12I;
            end else if (instruction[31:22] > 10'h001) begin    // 12-bit immediate forms
                case (instruction[31:22])
                    10'h008: dif.alu_op = ALU_SLTI;
                    10'h009: dif.alu_op = ALU_SLTUI;
                    10'h00a: dif.alu_op = ALU_ADDI;
                    10'h00d: dif.alu_op = ALU_ANDI;
                    10'h00e: dif.alu_op = ALU_ORI;
                    10'h00f: dif.alu_op = ALU_XORI;
                    default: dif.alu_op = alu_op_e'('0);
                endcase
            end else begin
                case (instruction[31:15])
                    17'h20:  dif.alu_op = ALU_ADD;
                    17'h22:  dif.alu_op = ALU_SUB;
                    17'h24:  dif.alu_op = ALU_SLT;
                    17'h25:  dif.alu_op = ALU_SLTU;
                    17'h28:  dif.alu_op = ALU_NOR;
                    17'h29:  dif.alu_op = ALU_AND;
                    17'h2a:  dif.alu_op = ALU_OR;
                    17'h2b:  dif.alu_op = ALU_XOR;
                    17'h2e:  dif.alu_op = ALU_SLL;
                    17'h2f:  dif.alu_op = ALU_SRL;
                    17'h30:  dif.alu_op = ALU_SRA;
                    17'h81:  dif.alu_op = ALU_SLLI;
                    17'h89:  dif.alu_op = ALU_SRLI;
                    17'h91:  dif.alu_op = ALU_SRAI;
                    default: dif.alu_op = alu_op_e'('0);
                endcase
            end
        end
    end

    always_comb begin
        dif.mdu_op = mdu_op_e'('0);
        if (dif.unit == IQ_MDU) begin
            case (instruction[31:15])
                17'h38:  dif.mdu_op = MDU_MUL;
                17'h39:  dif.mdu_op = MDU_MULH;
                17'h3a:  dif.mdu_op = MDU_MULHU;
                17'h40:  dif.mdu_op = MDU_DIV;
                17'h41:  dif.mdu_op = MDU_MOD;
                17'h42:  dif.mdu_op = MDU_DIVU;
                17'h43:  dif.mdu_op = MDU_MODU;
                default: dif.mdu_op = mdu_op_e'('0);
            endcase
        end
    end

    // LU12I carries 20 bits, everything else 12
    assign dif.alu_imm = (dif.unit != IQ_ALU) ? '0 :
                         is_lu12i ? instruction[24:5] : {8'd0, instruction[21:10]};

endmodule

//--- src/branch_decoder.sv
`timescale 1ns/1ps

module branch_decoder import decode_pkg::*; (
    input  logic [instr_w-1:0] instruction,
    decode_if.bru_mp           dif
);

    bru_op_e op;

    always_comb begin
        op = bru_op_e'('0);
        if (dif.unit == IQ_BRU && instruction[31:25] != 7'h0e) begin
            case (instruction[31:26])
                6'h13:   op = BRU_JIRL;
                6'h14:   op = BRU_B;
                6'h15:   op = BRU_BL;
                6'h16:   op = BRU_BEQ;
                6'h17:   op = BRU_BNE;
                6'h18:   op = BRU_BLT;
                6'h19:   op = BRU_BGE;
                6'h1a:   op = BRU_BLTU;
                6'h1b:   op = BRU_BGEU;
                default: op = bru_op_e'('0);
            endcase
        end
    end

    always_comb begin
        if (dif.unit != IQ_BRU) begin
            dif.bru_imm = '0;
        end else if (op == BRU_PCADDU12I) begin
            dif.bru_imm = {6'd0, instruction[24:5]};
        end else if (op == BRU_B || op == BRU_BL) begin
            dif.bru_imm = {instruction[9:0], instruction[25:10]};    // offs[25:16] sits low
        end else begin
            dif.bru_imm = {10'd0, instruction[25:10]};
        end
    end

    assign dif.bru_op = op;

endmodule

//--- src/decode_if.sv
`timescale 1ns/1ps

interface decode_if import decode_pkg::*; ();

    issue_unit_e                 unit;
    logic                        recognized;
    alu_op_e                     alu_op;
    mdu_op_e                     mdu_op;
    logic        [alu_imm_w-1:0] alu_imm;
    bru_op_e                     bru_op;
    logic        [bru_imm_w-1:0] bru_imm;
    logic                        dest_en;
    logic       [reg_addr_w-1:0] dest;
    logic                        src1_en;
    logic       [reg_addr_w-1:0] src1;
    logic                        src2_en;
    logic       [reg_addr_w-1:0] src2;

    modport classifier_mp (output unit, recognized);
    modport alu_mp (input unit, output alu_op, mdu_op, alu_imm);
    modport bru_mp (input unit, output bru_op, bru_imm);
    modport operand_mp (input unit, output dest_en, dest, src1_en, src1, src2_en, src2);
    modport stage_mp (
        input unit, recognized, alu_op, mdu_op, alu_imm, bru_op, bru_imm,
        input dest_en, dest, src1_en, src1, src2_en, src2
    );

endinterface

//--- src/decode_pkg.sv
package decode_pkg;

    localparam int instr_w      = 32;
    localparam int reg_addr_w   = 5;
    localparam int alu_imm_w    = 20;
    localparam int bru_imm_w    = 26;
    localparam int except_in_w  = 2;
    localparam int except_out_w = 3;

    // Top bit of except_out marks an undecodable instruction
    localparam logic [except_out_w-1:0] except_illegal = 3'b100;

    typedef enum logic [1:0] {
        IQ_NONE = 2'd0,
        IQ_ALU  = 2'd1,
        IQ_MDU  = 2'd2,
        IQ_BRU  = 2'd3
    } issue_unit_e;

    typedef enum logic [4:0] {
        ALU_LU12I = 5'd0,
        ALU_SLTI  = 5'd1,
        ALU_SLTUI = 5'd2,
        ALU_ADDI  = 5'd3,
        ALU_ANDI  = 5'd4,
        ALU_ORI   = 5'd5,
        ALU_XORI  = 5'd6,
        ALU_ADD   = 5'd7,
        ALU_SUB   = 5'd8,
        ALU_SLT   = 5'd9,
        ALU_SLTU  = 5'd10,
        ALU_NOR   = 5'd11,
        ALU_AND   = 5'd12,
        ALU_OR    = 5'd13,
        ALU_XOR   = 5'd14,
        ALU_SLL   = 5'd15,
        ALU_SRL   = 5'd16,
        ALU_SRA   = 5'd17,
        ALU_SLLI  = 5'd21,    // 18..20 were counter reads
        ALU_SRLI  = 5'd22,
        ALU_SRAI  = 5'd23
    } alu_op_e;

    typedef enum logic [2:0] {
        MDU_DIV   = 3'd0,
        MDU_MOD   = 3'd1,
        MDU_DIVU  = 3'd2,
        MDU_MODU  = 3'd3,
        MDU_MUL   = 3'd4,
        MDU_MULH  = 3'd5,
        MDU_MULHU = 3'd6
    } mdu_op_e;

    typedef enum logic [3:0] {
        BRU_PCADDU12I = 4'd0,
        BRU_JIRL      = 4'd1,
        BRU_B         = 4'd2,
        BRU_BL        = 4'd3,
        BRU_BEQ       = 4'd4,
        BRU_BNE       = 4'd5,
        BRU_BLT       = 4'd6,
        BRU_BGE       = 4'd7,
        BRU_BLTU      = 4'd8,
        BRU_BGEU      = 4'd9
    } bru_op_e;

endpackage

//--- src/decode_stage_reg.sv
`timescale 1ns/1ps

module decode_stage_reg import decode_pkg::*; #(
    parameter int pc_w = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    hold,
    input  logic [except_in_w-1:0]  except_in,
    input  logic [pc_w-1:0]         pc_in,
    input  logic                    instruction_vld,
    decode_if.stage_mp              dif,
    output logic [pc_w-1:0]         pc_out,
    output logic [except_out_w-1:0] except_out,
    output logic                    decode_vld,
    output issue_unit_e             issue_unit,
    output alu_op_e                 alu_op,
    output mdu_op_e                 mdu_op,
    output bru_op_e                 bru_op,
    output logic [alu_imm_w-1:0]    alu_imm,
    output logic [bru_imm_w-1:0]    bru_imm,
    output logic                    dest_en,
    output logic [reg_addr_w-1:0]   dest,
    output logic                    src1_en,
    output logic [reg_addr_w-1:0]   src1,
    output logic                    src2_en,
    output logic [reg_addr_w-1:0]   src2
);

    logic has_except;
    logic capture;

    assign has_except = |except_in;
    assign capture    = instruction_vld && !has_except;    // An incoming exception wins

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_out <= '0;
        end else if (flush) begin
            pc_out <= '0;
        end else if (!hold && (has_except || instruction_vld)) begin
            pc_out <= pc_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            except_out <= '0;
        end else if (flush) begin
            except_out <= '0;
        end else if (!hold) begin
            if (has_except) begin
                except_out <= {{(except_out_w-except_in_w){1'b0}}, except_in};
            end else if (instruction_vld) begin
                except_out <= dif.recognized ? '0 : except_illegal;
            end else begin
                except_out <= '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decode_vld <= 1'b0;
            issue_unit <= IQ_NONE;
            alu_op     <= alu_op_e'('0);
            mdu_op     <= mdu_op_e'('0);
            bru_op     <= bru_op_e'('0);
            alu_imm    <= '0;
            bru_imm    <= '0;
            dest_en    <= 1'b0;
            dest       <= '0;
            src1_en    <= 1'b0;
            src1       <= '0;
            src2_en    <= 1'b0;
            src2       <= '0;
        end else if (flush || (!hold && !capture)) begin
            decode_vld <= 1'b0;
            issue_unit <= IQ_NONE;
            alu_op     <= alu_op_e'('0);
            mdu_op     <= mdu_op_e'('0);
            bru_op     <= bru_op_e'('0);
            alu_imm    <= '0;
            bru_imm    <= '0;
            dest_en    <= 1'b0;
            dest       <= '0;
            src1_en    <= 1'b0;
            src1       <= '0;
            src2_en    <= 1'b0;
            src2       <= '0;
        end else if (!hold) begin
            decode_vld <= dif.recognized;
            issue_unit <= dif.unit;
            alu_op     <= dif.alu_op;
            mdu_op     <= dif.mdu_op;
            bru_op     <= dif.bru_op;
            alu_imm    <= dif.alu_imm;
            bru_imm    <= dif.bru_imm;
            dest_en    <= dif.dest_en;
            dest       <= dif.dest;
            src1_en    <= dif.src1_en;
            src1       <= dif.src1;
            src2_en    <= dif.src2_en;
            src2       <= dif.src2;
        end
    end

endmodule

//--- src/decode_top.sv
`timescale 1ns/1ps

module decode_top import decode_pkg::*; #(
    parameter int pc_w = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    hold,
    input  logic [except_in_w-1:0]  except_in,
    input  logic [pc_w-1:0]         pc_in,
    input  logic                    instruction_vld,
    input  logic [instr_w-1:0]      instruction,
    output logic [pc_w-1:0]         pc_out,
    output logic [except_out_w-1:0] except_out,
    output logic                    decode_vld,
    output issue_unit_e             issue_unit,
    output alu_op_e                 alu_op,
    output mdu_op_e                 mdu_op,
    output bru_op_e                 bru_op,
    output logic [alu_imm_w-1:0]    alu_imm,
    output logic [bru_imm_w-1:0]    bru_imm,
    output logic                    dest_en,
    output logic [reg_addr_w-1:0]   dest,
    output logic                    src1_en,
    output logic [reg_addr_w-1:0]   src1,
    output logic                    src2_en,
    output logic [reg_addr_w-1:0]   src2
);

    decode_if dif ();

    issue_classifier u_classifier (
        .instruction     (instruction),
        .instruction_vld (instruction_vld),
        .dif             (dif)
    );

    alu_decoder u_alu_dec (.instruction(instruction), .dif(dif));

    branch_decoder u_bru_dec (.instruction(instruction), .dif(dif));

    operand_decoder u_opnd_dec (.instruction(instruction), .dif(dif));

    decode_stage_reg #(.pc_w(pc_w)) u_stage_reg (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .hold            (hold),
        .except_in       (except_in),
        .pc_in           (pc_in),
        .instruction_vld (instruction_vld),
        .dif             (dif),
        .pc_out          (pc_out),
        .except_out      (except_out),
        .decode_vld      (decode_vld),
        .issue_unit      (issue_unit),
        .alu_op          (alu_op),
        .mdu_op          (mdu_op),
        .bru_op          (bru_op),
        .alu_imm         (alu_imm),
        .bru_imm         (bru_imm),
        .dest_en         (dest_en),
        .dest            (dest),
        .src1_en         (src1_en),
        .src1            (src1),
        .src2_en         (src2_en),
        .src2            (src2)
    );

endmodule

//--- src/issue_classifier.sv
`timescale 1ns/1ps

module issue_classifier import decode_pkg::*; (
    input  logic [instr_w-1:0] instruction,
    input  logic               instruction_vld,
    decode_if.classifier_mp    dif
);

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;
    logic        is_alu;
    logic        is_mdu;
    logic        is_bru;

    assign op17 = instruction[31:15];
    assign op10 = instruction[31:22];
    assign op7  = instruction[31:25];
    assign op6  = instruction[31:26];

    // LU12I, 12-bit immediate forms, register forms, immediate shifts
    assign is_alu = (op7 == 7'h0a) ||
                    (op10 inside {10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f}) ||
                    (op17 inside {17'h20, 17'h22, 17'h24, 17'h25, 17'h28, 17'h29,
                                  17'h2a, 17'h2b, 17'h2e, 17'h2f, 17'h30}) ||
                    (op17 inside {17'h81, 17'h89, 17'h91});

    assign is_mdu = op17 inside {17'h38, 17'h39, 17'h3a, [17'h40:17'h43]};

    assign is_bru = (op7 == 7'h0e) ||    // PCADDU12I
                    (op6 inside {[6'h13:6'h1b]});

    always_comb begin
        dif.unit = IQ_NONE;
        if (instruction_vld) begin
            if (is_alu) begin
                dif.unit = IQ_ALU;
            end else if (is_mdu) begin
                dif.unit = IQ_MDU;
            end else if (is_bru) begin
                dif.unit = IQ_BRU;
            end
        end
    end

    assign dif.recognized = instruction_vld && (is_alu || is_mdu || is_bru);

endmodule

//--- src/operand_decoder.sv
`timescale 1ns/1ps

module operand_decoder import decode_pkg::*; (
    input  logic [instr_w-1:0] instruction,
    decode_if.operand_mp       dif
);

    logic is_alu;
    logic is_mdu;
    logic is_bru;
    logic is_lu12i;
    logic alu_reg_form;
    logic is_pcaddu;
    logic is_jirl;
    logic is_b;
    logic is_bl;
    logic is_cond;

    assign is_alu = (dif.unit == IQ_ALU);
    assign is_mdu = (dif.unit == IQ_MDU);
    assign is_bru = (dif.unit == IQ_BRU);

    assign is_lu12i     = is_alu && (instruction[31:25] == 7'h0a);
    assign alu_reg_form = is_alu && (instruction[31:22] == 10'h000);    // shifts-by-imm are 0x001

    assign is_pcaddu = is_bru && (instruction[31:25] == 7'h0e);
    assign is_jirl   = is_bru && (instruction[31:26] == 6'h13);
    assign is_b      = is_bru && (instruction[31:26] == 6'h14);
    assign is_bl     = is_bru && (instruction[31:26] == 6'h15);
    assign is_cond   = is_bru && (instruction[31:26] inside {[6'h16:6'h1b]});

    always_comb begin
        dif.dest    = '0;
        dif.src1    = '0;
        dif.src2    = '0;
        if (dif.unit != IQ_NONE) begin
            dif.dest = is_bl ? reg_addr_w'(1) : instruction[4:0];    // BL links to r1
            dif.src1 = instruction[9:5];
            dif.src2 = is_cond ? instruction[4:0] : instruction[14:10];
        end
    end

    assign dif.dest_en = is_alu || is_mdu || is_jirl || is_bl || is_pcaddu;
    assign dif.src1_en = (dif.unit != IQ_NONE) && !is_lu12i && !is_b && !is_bl && !is_pcaddu;
    assign dif.src2_en = alu_reg_form || is_mdu || is_cond;

endmodule
